/* fe_pkg.sv */
package fe_pkg;

    // ----------------------------------------------------------
    // Instruction format
    // ----------------------------------------------------------

    typedef enum logic [3:0] {
        op_nop    = 4'd0,
        op_alu    = 4'd1,
        op_load   = 4'd2,
        op_store  = 4'd3,
        op_branch = 4'd4
    } opcode_e;

    // Raw memory word, opcode kept as bits so unknown codes survive.
    typedef struct packed {
        logic [3:0]  opcode;    // Bits 31:28.
        logic [3:0]  rd;
        logic [3:0]  rs1;
        logic [3:0]  rs2;
        logic [15:0] imm;
    } instr_t;

    typedef struct packed {
        opcode_e     op;
        logic [3:0]  rd;
        logic [3:0]  rs1;
        logic [3:0]  rs2;
        logic [15:0] imm;
    } dec_instr_t;

    // ----------------------------------------------------------
    // Pipeline and bus bundles
    // ----------------------------------------------------------

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;        // Byte address.
        opcode_e     op;
        logic [3:0]  rd;
        logic [3:0]  rs1;
        logic [3:0]  rs2;
        logic [15:0] imm;
    } issue_slot_t;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic [31:0] adr;
    } wb_req_t;

endpackage

/* fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit #(
    parameter logic [31:0] reset_pc = 32'h0000_0000
) (
    input  logic             clk,
    input  logic             rst,

    output fe_pkg::wb_req_t  wb_req,
    input  logic             wb_ack,
    input  logic [63:0]      wb_dat,

    input  logic             fifo_full,
    output logic             write_en1,
    output logic             write_en2,
    output fe_pkg::instr_t   write_data1,
    output fe_pkg::instr_t   write_data2,
    output logic [31:0]      write_pc
);

    typedef enum logic {
        idle,
        wait_ack
    } fetch_state_e;

    fetch_state_e state;
    fetch_state_e state_next;
    logic [31:0]  fetch_pc;
    logic         done;

    assign done = (state == wait_ack) && wb_ack;

    // ----------------------------------------------------------
    // Request FSM
    // ----------------------------------------------------------

    always_comb begin
        state_next = state;
        case (state)
            idle: begin
                if (!fifo_full)
                    state_next = wait_ack;  // Full is settled after the last write.
            end
            wait_ack: begin
                if (wb_ack)
                    state_next = idle;
            end
            default: state_next = idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= idle;
            fetch_pc <= reset_pc;
        end else begin
            state <= state_next;
            if (done)
                fetch_pc <= fetch_pc + 32'd8;
        end
    end

    // Request lines straight from the state register.
    assign wb_req.cyc = (state == wait_ack);
    assign wb_req.stb = (state == wait_ack);
    assign wb_req.adr = fetch_pc;

    // ----------------------------------------------------------
    // Queue write in the ack cycle
    // ----------------------------------------------------------

    assign write_en1   = done;
    assign write_en2   = done;
    assign write_data1 = fe_pkg::instr_t'(wb_dat[31:0]);   // Instruction at adr.
    assign write_data2 = fe_pkg::instr_t'(wb_dat[63:32]);  // Instruction at adr+4.
    assign write_pc    = fetch_pc;

    a_req_held: assert property (@(posedge clk) disable iff (rst)
        (wb_req.stb && !wb_ack) |=>
            (wb_req.cyc && wb_req.stb && $stable(wb_req.adr)));

endmodule

/* frontend_top.sv */
`timescale 1ns/1ps

module frontend_top #(
    parameter int          fifo_depth = 16,
    parameter logic [31:0] reset_pc   = 32'h0000_0000
) (
    input  logic                 clk,
    input  logic                 rst,

    output fe_pkg::wb_req_t      wb_req,
    output logic                 wb_we,
    input  logic                 wb_ack,
    input  logic [63:0]          wb_dat,

    input  logic                 issue_ready,
    output fe_pkg::issue_slot_t  slot0,
    output fe_pkg::issue_slot_t  slot1
);

    // ----------------------------------------------------------
    // Fetch to queue to issue
    // ----------------------------------------------------------

    logic           write_en1;
    logic           write_en2;
    fe_pkg::instr_t write_data1;
    fe_pkg::instr_t write_data2;
    logic [31:0]    write_pc;
    logic           read_en1;
    logic           read_en2;
    fe_pkg::instr_t data_out1;
    fe_pkg::instr_t data_out2;
    logic [31:0]    pc_out1;
    logic [31:0]    pc_out2;
    logic           empty;
    logic           almost_empty;
    logic           full;

    assign wb_we = 1'b0;  // Read-only master.

    fetch_unit #(
        .reset_pc (reset_pc)
    ) i_fetch (
        .clk         (clk),
        .rst         (rst),
        .wb_req      (wb_req),
        .wb_ack      (wb_ack),
        .wb_dat      (wb_dat),
        .fifo_full   (full),
        .write_en1   (write_en1),
        .write_en2   (write_en2),
        .write_data1 (write_data1),
        .write_data2 (write_data2),
        .write_pc    (write_pc)
    );

    instr_fifo #(
        .fifo_depth (fifo_depth)
    ) i_fifo (
        .clk          (clk),
        .rst          (rst),
        .write_en1    (write_en1),
        .write_en2    (write_en2),
        .write_data1  (write_data1),
        .write_data2  (write_data2),
        .write_pc     (write_pc),
        .read_en1     (read_en1),
        .read_en2     (read_en2),
        .data_out1    (data_out1),
        .data_out2    (data_out2),
        .pc_out1      (pc_out1),
        .pc_out2      (pc_out2),
        .empty        (empty),
        .almost_empty (almost_empty),
        .full         (full)
    );

    issue_stage i_issue (
        .clk          (clk),
        .rst          (rst),
        .data_in1     (data_out1),
        .data_in2     (data_out2),
        .pc_in1       (pc_out1),
        .pc_in2       (pc_out2),
        .empty        (empty),
        .almost_empty (almost_empty),
        .read_en1     (read_en1),
        .read_en2     (read_en2),
        .issue_ready  (issue_ready),
        .slot0        (slot0),
        .slot1        (slot1)
    );

endmodule

/* instr_fifo.sv */
`timescale 1ns/1ps

module instr_fifo #(
    parameter int fifo_depth = 16
) (
    input  logic             clk,
    input  logic             rst,

    input  logic             write_en1,
    input  logic             write_en2,
    input  fe_pkg::instr_t   write_data1,
    input  fe_pkg::instr_t   write_data2,
    input  logic [31:0]      write_pc,

    input  logic             read_en1,
    input  logic             read_en2,

    output fe_pkg::instr_t   data_out1,
    output fe_pkg::instr_t   data_out2,
    output logic [31:0]      pc_out1,
    output logic [31:0]      pc_out2,
    output logic             empty,
    output logic             almost_empty,
    output logic             full
);

    localparam int ptr_w = $clog2(fifo_depth);
    localparam int cnt_w = ptr_w + 1;

    fe_pkg::instr_t mem    [fifo_depth];
    logic [31:0]    pc_mem [fifo_depth];

    logic [ptr_w-1:0] write_ptr;
    logic [ptr_w-1:0] read_ptr;
    logic [ptr_w-1:0] write_ptr2;
    logic [ptr_w-1:0] read_ptr2;
    logic [cnt_w-1:0] count;
    logic [cnt_w-1:0] count_next;
    logic [cnt_w-1:0] n_wr;
    logic [cnt_w-1:0] n_rd;

    assign n_wr = cnt_w'(write_en1) + cnt_w'(write_en2);
    assign n_rd = cnt_w'(read_en1) + cnt_w'(read_en2);
    assign count_next = count + n_wr - n_rd;

    assign write_ptr2 = write_ptr + ptr_w'(write_en1);  // Lane 2 slot.
    assign read_ptr2  = read_ptr + ptr_w'(1);

    // ----------------------------------------------------------
    // Head of queue
    // ----------------------------------------------------------

    assign data_out1 = mem[read_ptr];
    assign data_out2 = mem[read_ptr2];
    assign pc_out1   = pc_mem[read_ptr];
    assign pc_out2   = pc_mem[read_ptr2];

    // ----------------------------------------------------------
    // Pointers, occupancy and flags
    // ----------------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            write_ptr    <= '0;
            read_ptr     <= '0;
            count        <= '0;
            empty        <= 1'b1;
            almost_empty <= 1'b0;
            full         <= 1'b0;
        end else begin
            write_ptr    <= write_ptr + ptr_w'(n_wr);
            read_ptr     <= read_ptr + ptr_w'(n_rd);
            count        <= count_next;
            empty        <= (count_next == '0);
            almost_empty <= (count_next == cnt_w'(1));
            full         <= (count_next > cnt_w'(fifo_depth - 2));  // Under two free.
        end
    end

    always_ff @(posedge clk) begin
        if (write_en1) begin
            mem[write_ptr]    <= write_data1;
            pc_mem[write_ptr] <= write_pc;
        end
        if (write_en2) begin
            mem[write_ptr2]    <= write_data2;
            pc_mem[write_ptr2] <= write_pc + 32'd4;
        end
    end

    // Producer and consumer sit in other modules.
    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        (write_en1 || write_en2) |-> !full);

    a_no_underflow: assert property (@(posedge clk) disable iff (rst)
        (read_en1 |-> !empty) and (read_en2 |-> (read_en1 && !almost_empty)));

endmodule

/* issue_stage.sv */
`timescale 1ns/1ps

module issue_stage (
    input  logic                 clk,
    input  logic                 rst,

    input  fe_pkg::instr_t       data_in1,
    input  fe_pkg::instr_t       data_in2,
    input  logic [31:0]          pc_in1,
    input  logic [31:0]          pc_in2,
    input  logic                 empty,
    input  logic                 almost_empty,
    output logic                 read_en1,
    output logic                 read_en2,

    input  logic                 issue_ready,
    output fe_pkg::issue_slot_t  slot0,
    output fe_pkg::issue_slot_t  slot1
);

    fe_pkg::dec_instr_t dec0;
    fe_pkg::dec_instr_t dec1;
    logic               can_load;
    logic               have1;
    logic               pair_ok;

    function automatic fe_pkg::dec_instr_t decode(input fe_pkg::instr_t ins);
        fe_pkg::dec_instr_t d;
        if (ins.opcode > 4'(fe_pkg::op_branch))
            d.op = fe_pkg::op_nop;  // Unknown codes.
        else
            d.op = fe_pkg::opcode_e'(ins.opcode);
        d.rd  = ins.rd;
        d.rs1 = ins.rs1;
        d.rs2 = ins.rs2;
        d.imm = ins.imm;
        return d;
    endfunction

    function automatic logic writes_rd(input fe_pkg::opcode_e op);
        return (op == fe_pkg::op_alu) || (op == fe_pkg::op_load);
    endfunction

    function automatic logic is_mem(input fe_pkg::opcode_e op);
        return (op == fe_pkg::op_load) || (op == fe_pkg::op_store);
    endfunction

    assign dec0 = decode(data_in1);
    assign dec1 = decode(data_in2);

    // ----------------------------------------------------------
    // Pairing and pop
    // ----------------------------------------------------------

    assign have1 = !empty && !almost_empty;

    assign pair_ok = have1
        && (dec0.op != fe_pkg::op_branch)
        && !(writes_rd(dec0.op) && ((dec1.rs1 == dec0.rd) || (dec1.rs2 == dec0.rd)))
        && !(is_mem(dec0.op) && is_mem(dec1.op));

    assign can_load = issue_ready || !slot0.valid;
    assign read_en1 = can_load && !empty;
    assign read_en2 = read_en1 && pair_ok;

    // ----------------------------------------------------------
    // Issue registers
    // ----------------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            slot0.valid <= 1'b0;
            slot1.valid <= 1'b0;
        end else if (can_load) begin
            slot0.valid <= read_en1;
            slot0.pc    <= pc_in1;
            slot0.op    <= dec0.op;
            slot0.rd    <= dec0.rd;
            slot0.rs1   <= dec0.rs1;
            slot0.rs2   <= dec0.rs2;
            slot0.imm   <= dec0.imm;
            slot1.valid <= read_en2;
            slot1.pc    <= pc_in2;
            slot1.op    <= dec1.op;
            slot1.rd    <= dec1.rd;
            slot1.rs1   <= dec1.rs1;
            slot1.rs2   <= dec1.rs2;
            slot1.imm   <= dec1.imm;
        end
    end

    a_slot_order: assert property (@(posedge clk) disable iff (rst)
        slot1.valid |-> slot0.valid);

endmodule

/* project.f */
fe_pkg.sv
instr_fifo.sv
fetch_unit.sv
issue_stage.sv
frontend_top.sv
tb_wb_mem.sv
tb_frontend.sv

/* tb_frontend.sv */
`timescale 1ns/1ps

module tb_frontend;

    localparam int          fifo_depth      = 16;
    localparam logic [31:0] reset_pc        = 32'h0000_0100;
    localparam int          target          = 200;
    localparam int          watchdog_cycles = 256 * 8 + 400;

    logic                clk;
    logic                rst;
    logic                issue_ready;
    fe_pkg::wb_req_t     wb_req;
    logic                wb_we;
    logic                wb_ack;
    logic [63:0]         wb_dat;
    fe_pkg::issue_slot_t slot0;
    fe_pkg::issue_slot_t slot1;

    logic [31:0] ref_mem [256];
    integer      seed;
    logic [31:0] rnd;
    logic [31:0] exp_adr;
    logic [31:0] exp_pc;
    logic [31:0] arrived;      // Bytes written to the queue so far.
    logic [31:0] pop_arrived;  // Arrived bytes when the slots last loaded.
    logic        cyc_q;
    int          issued;
    int          acks_since;

    frontend_top #(
        .fifo_depth (fifo_depth),
        .reset_pc   (reset_pc)
    ) i_dut (
        .clk         (clk),
        .rst         (rst),
        .wb_req      (wb_req),
        .wb_we       (wb_we),
        .wb_ack      (wb_ack),
        .wb_dat      (wb_dat),
        .issue_ready (issue_ready),
        .slot0       (slot0),
        .slot1       (slot1)
    );

    tb_wb_mem i_mem (
        .clk    (clk),
        .rst    (rst),
        .wb_req (wb_req),
        .wb_ack (wb_ack),
        .wb_dat (wb_dat)
    );

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    function automatic fe_pkg::opcode_e op_of(input logic [31:0] word);
        if (word[31:28] > fe_pkg::op_branch)
            return fe_pkg::op_nop;
        return fe_pkg::opcode_e'(word[31:28]);
    endfunction

    function automatic fe_pkg::issue_slot_t expected_slot(input logic [31:0] pc);
        logic [31:0]         word;
        fe_pkg::issue_slot_t s;
        word    = ref_mem[pc[9:2]];
        s.valid = 1'b1;
        s.pc    = pc;
        s.op    = op_of(word);
        s.rd    = word[27:24];
        s.rs1   = word[23:20];
        s.rs2   = word[19:16];
        s.imm   = word[15:0];
        return s;
    endfunction

    // True when b may issue beside a. The caller checks that b is present.
    function automatic logic may_pair(input fe_pkg::issue_slot_t a,
                                      input fe_pkg::issue_slot_t b);
        logic a_writes;
        logic hazard;
        logic both_mem;
        a_writes = (a.op == fe_pkg::op_alu) || (a.op == fe_pkg::op_load);
        hazard   = a_writes && ((b.rs1 == a.rd) || (b.rs2 == a.rd));
        both_mem = (a.op inside {fe_pkg::op_load, fe_pkg::op_store})
                && (b.op inside {fe_pkg::op_load, fe_pkg::op_store});
        return (a.op != fe_pkg::op_branch) && !hazard && !both_mem;
    endfunction

    task automatic check_slot(input string name, input fe_pkg::issue_slot_t got,
                              input logic [31:0] pc);
        fe_pkg::issue_slot_t exp;
        exp = expected_slot(pc);
        assert (got === exp)
            else fail_run($sformatf("error: %s got %h expected %h", name, got, exp));
    endtask

    // ----------------------------------------------------------
    // Protocol and issue assertions
    // ----------------------------------------------------------

    a_reset_idle: assert property (@(posedge clk) $fell(rst) |->
        (!wb_req.cyc && !wb_req.stb && !slot0.valid && !slot1.valid))
        else fail_run("bus or issue slots active in the first cycle after reset");

    a_we_low: assert property (@(posedge clk) disable iff (rst) !wb_we)
        else fail_run($sformatf("error: wb_we got %h expected %h", wb_we, 1'b0));

    a_stb_cyc: assert property (@(posedge clk) disable iff (rst) wb_req.stb |-> wb_req.cyc)
        else fail_run("stb raised without cyc");

    a_req_hold: assert property (@(posedge clk) disable iff (rst)
        (wb_req.stb && !wb_ack) |=> (wb_req.cyc && wb_req.stb && $stable(wb_req.adr)))
        else fail_run("request dropped or address changed before ack");

    a_cyc_drop: assert property (@(posedge clk) disable iff (rst)
        (wb_req.cyc && wb_ack) |=> !wb_req.cyc)
        else fail_run("cyc still high in the cycle after ack");

    a_slot_order: assert property (@(posedge clk) disable iff (rst) slot1.valid |-> slot0.valid)
        else fail_run("slot1 valid without slot0 valid");

    a_pairing: assert property (@(posedge clk) disable iff (rst)
        slot1.valid |-> may_pair(slot0, slot1))
        else fail_run("slot1 issued although the pairing rule fails");

    a_hold: assert property (@(posedge clk) disable iff (rst)
        (slot0.valid && !issue_ready) |=>
            ((slot0 === $past(slot0)) && (slot1 === $past(slot1))))
        else fail_run("issue slots changed while stalled");

    // ----------------------------------------------------------
    // Reference model
    // ----------------------------------------------------------

    always @(posedge clk) begin
        if (rst) begin
            exp_adr     <= reset_pc;
            exp_pc      <= reset_pc;
            arrived     <= '0;
            pop_arrived <= '0;
            cyc_q       <= 1'b0;
            issued      <= 0;
            acks_since  <= 0;
        end else begin
            cyc_q <= wb_req.cyc;
            if (wb_req.cyc && !cyc_q) begin
                assert (wb_req.adr == exp_adr) else fail_run($sformatf(
                    "error: wb_req.adr got %h expected %h", wb_req.adr, exp_adr));
            end
            if (wb_req.cyc && wb_ack) begin
                exp_adr <= exp_adr + 32'd8;
                arrived <= arrived + 32'd8;
            end
            if (issue_ready || !slot0.valid)
                pop_arrived <= arrived;  // Queue content seen by this pop.
            if (slot0.valid && issue_ready) begin
                check_slot("slot0", slot0, exp_pc);
                if (slot1.valid) begin
                    check_slot("slot1", slot1, exp_pc + 32'd4);
                    exp_pc <= exp_pc + 32'd8;
                    issued <= issued + 2;
                end else begin
                    if (exp_pc + 32'd4 < reset_pc + pop_arrived) begin
                        assert (!may_pair(slot0, expected_slot(exp_pc + 32'd4)))
                            else fail_run("slot0 issued alone although its successor could pair");
                    end
                    exp_pc <= exp_pc + 32'd4;
                    issued <= issued + 1;
                end
                acks_since <= (wb_req.cyc && wb_ack) ? 1 : 0;
            end else if (wb_req.cyc && wb_ack) begin
                acks_since <= acks_since + 1;
            end
            assert (acks_since <= fifo_depth / 2 + 1) else fail_run($sformatf(
                "error: acks_since got %h expected at most %h", acks_since, fifo_depth / 2 + 1));
        end
    end

    // ----------------------------------------------------------
    // Clock, stimulus and watchdog
    // ----------------------------------------------------------

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        fail_run("timeout before all instructions were issued");
    end

    initial begin
        seed = 32'h57b4965a;
        for (int i = 0; i < 256; i++)
            ref_mem[i] = $random(seed);  // Same sequence as the memory model.
        rst         = 1'b1;
        issue_ready = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        repeat (200) begin
            @(negedge clk);
            rnd         = $random(seed);
            issue_ready = rnd[0];
        end
        @(negedge clk);
        issue_ready = 1'b0;  // Long stall fills the queue.
        repeat (200) @(negedge clk);
        issue_ready = 1'b1;
        while (issued < target)
            @(negedge clk);
        $display("Test completed successfully");
        $finish;
    end

endmodule

/* tb_wb_mem.sv */
`timescale 1ns/1ps

module tb_wb_mem (
    input  logic            clk,
    input  logic            rst,
    input  fe_pkg::wb_req_t wb_req,
    output logic            wb_ack,
    output logic [63:0]     wb_dat
);

    logic [31:0] mem [256];
    integer      seed;
    logic [31:0] rnd;
    logic [1:0]  wait_cnt;
    logic [7:0]  idx;
    logic [7:0]  idx_next;

    assign idx      = wb_req.adr[9:2];  // Word index, wraps over 1 KiB.
    assign idx_next = idx + 8'd1;

    initial begin
        seed   = 32'h57b4965a;
        wb_ack = 1'b0;
        wb_dat = '0;
        for (int i = 0; i < 256; i++)
            mem[i] = $random(seed);
    end

    // ----------------------------------------------------------
    // Classic single read with 0 to 3 wait cycles
    // ----------------------------------------------------------

    always @(posedge clk) begin
        if (rst) begin
            wb_ack   <= 1'b0;
            wb_dat   <= '0;
            wait_cnt <= 2'd0;
        end else if (wb_req.cyc && wb_req.stb && !wb_ack) begin
            if (wait_cnt == 2'd0) begin
                wb_ack <= 1'b1;
                wb_dat <= {mem[idx_next], mem[idx]};  // Upper word is adr+4.
            end else begin
                wait_cnt <= wait_cnt - 2'd1;
            end
        end else begin
            wb_ack <= 1'b0;
            if (wb_ack) begin
                rnd = $random(seed);
                wait_cnt <= rnd[1:0];  // Wait for the next request.
            end
        end
    end

endmodule
